// ==== verilog/bf_defs.svh ====
`ifndef BF_DEFS_SVH
`define BF_DEFS_SVH

// counters held in one bucket word
`define BF_NUM_BUCKETS 12

// bits per counter, saturates at all ones
`define BF_BUCKET_BITS 4

// hash address width per bank
`define BF_ADDR_BITS 6

// ingress queue depth, same as the sender's starting credits
`define BF_CREDITS 4

// request tag width
`define BF_TAG_BITS 4

`endif

// ==== verilog/bf_pkg.sv ====
`include "bf_defs.svh"

package bf_pkg;

   // insert for a data packet, remove for its ack
   typedef enum logic {
      OP_INSERT = 1'b0,
      OP_REMOVE = 1'b1
   } bf_op_e;

   typedef logic [`BF_BUCKET_BITS-1:0] bucket_t;

   // index 0 is the newest time slot
   typedef bucket_t [`BF_NUM_BUCKETS-1:0] bucket_word_t;

   typedef struct packed {
      bf_op_e                  op;
      logic [`BF_TAG_BITS-1:0] tag;
      logic [`BF_ADDR_BITS-1:0] hash0; // bank 0 word
      logic [`BF_ADDR_BITS-1:0] hash1; // bank 1 word
   } bf_req_t;

   typedef struct packed {
      bf_op_e                  op;
      logic [`BF_TAG_BITS-1:0] tag;
      logic                    hit;  // both words nonzero before the update
   } bf_rsp_t;

endpackage

// ==== verilog/bf_req_ingress.sv ====
`include "bf_defs.svh"

module bf_req_ingress
   import bf_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     req_valid,
   input  bf_req_t                  req,
   output logic                     credit_return,
   output logic                     s1_valid,
   output bf_req_t                  s1_req,
   output logic [`BF_ADDR_BITS-1:0] rd_addr0,
   output logic [`BF_ADDR_BITS-1:0] rd_addr1
);

   localparam int PTR_W = $clog2(`BF_CREDITS);

   bf_req_t          q_mem [`BF_CREDITS];
   logic [PTR_W:0]   wr_ptr;  // extra bit tells full from empty
   logic [PTR_W:0]   rd_ptr;
   logic             q_empty;
   logic             q_full;
   logic             push;
   logic             pop;
   bf_req_t          head;

   assign q_empty = (wr_ptr == rd_ptr);
   assign q_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                    (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

   // credits keep the sender from overrunning, full is only a guard
   assign push = req_valid && !q_full;
   assign pop  = !q_empty;

   assign head = q_mem[rd_ptr[PTR_W-1:0]];

   // bank reads start in the pop cycle
   assign rd_addr0      = head.hash0;
   assign rd_addr1      = head.hash1;
   assign credit_return = pop;

   always_ff @(posedge clk) begin
      if (push) begin
         q_mem[wr_ptr[PTR_W-1:0]] <= req;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // stage 1 lines up with the bank read data
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= pop;
      end
   end

   always_ff @(posedge clk) begin
      s1_req <= head;
   end

endmodule

// ==== verilog/bf_bucket_bank.sv ====
`include "bf_defs.svh"

module bf_bucket_bank
   import bf_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [`BF_ADDR_BITS-1:0] rd_addr,
   input  logic                     wr_en,
   input  logic [`BF_ADDR_BITS-1:0] wr_addr,
   input  bucket_word_t             wr_word,
   output bucket_word_t             rd_word
);

   localparam int NUM_WORDS = 1 << `BF_ADDR_BITS;

   bucket_word_t           mem [NUM_WORDS];
   logic [NUM_WORDS-1:0]   word_vld;  // cleared on reset, so the table starts empty

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         word_vld <= '0;
      end else if (wr_en) begin
         word_vld[wr_addr] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_word;
      end
   end

   // read before write on a same-cycle hit
   always_ff @(posedge clk) begin
      if (word_vld[rd_addr]) begin
         rd_word <= mem[rd_addr];
      end else begin
         rd_word <= '0;   // never written
      end
   end

endmodule

// ==== verilog/bf_bucket_update.sv ====
`include "bf_defs.svh"

module bf_bucket_update
   import bf_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     s1_valid,
   input  bf_req_t                  s1_req,
   input  bucket_word_t             rd_word0,
   input  bucket_word_t             rd_word1,
   output logic                     wr_en,
   output logic [`BF_ADDR_BITS-1:0] wr_addr0,
   output logic [`BF_ADDR_BITS-1:0] wr_addr1,
   output bucket_word_t             wr_word0,
   output bucket_word_t             wr_word1,
   output logic                     rsp_valid,
   output bf_rsp_t                  rsp
);

   localparam bucket_t BKT_MAX = '1;

   // write committed to the banks one cycle ago
   logic                     hist_en;
   logic [`BF_ADDR_BITS-1:0] hist_addr0;
   logic [`BF_ADDR_BITS-1:0] hist_addr1;
   bucket_word_t             hist_word0;
   bucket_word_t             hist_word1;

   bucket_word_t cur_word0;
   bucket_word_t cur_word1;
   bucket_word_t nxt_word0;
   bucket_word_t nxt_word1;
   logic         present0;
   logic         present1;

   // the write going out this cycle is newer than the committed one,
   // and neither is visible yet in the bank read data
   function automatic bucket_word_t fwd_word(
      input logic [`BF_ADDR_BITS-1:0] addr,
      input bucket_word_t             bank_word,
      input logic                     new_en,
      input logic [`BF_ADDR_BITS-1:0] new_addr,
      input bucket_word_t             new_word,
      input logic                     old_en,
      input logic [`BF_ADDR_BITS-1:0] old_addr,
      input bucket_word_t             old_word
   );
      bucket_word_t sel;
      sel = bank_word;
      if (new_en && new_addr == addr) begin
         sel = new_word;
      end else if (old_en && old_addr == addr) begin
         sel = old_word;
      end
      return sel;
   endfunction

   // insert bumps slot 0, remove takes one from the lowest nonzero slot
   function automatic bucket_word_t lane_update(
      input bf_op_e       op,
      input bucket_word_t cur
   );
      bucket_word_t nxt;
      logic         found;
      nxt   = cur;
      found = 1'b0;
      if (op == OP_INSERT) begin
         if (cur[0] != BKT_MAX) begin
            nxt[0] = cur[0] + 1'b1;   // saturating
         end
      end else begin
         for (int i = 0; i < `BF_NUM_BUCKETS; i++) begin
            if (!found && cur[i] != '0) begin
               nxt[i] = cur[i] - 1'b1;
               found  = 1'b1;
            end
         end
      end
      return nxt;
   endfunction

   always_comb begin
      cur_word0 = fwd_word(s1_req.hash0, rd_word0, wr_en, wr_addr0, wr_word0,
                           hist_en, hist_addr0, hist_word0);
      cur_word1 = fwd_word(s1_req.hash1, rd_word1, wr_en, wr_addr1, wr_word1,
                           hist_en, hist_addr1, hist_word1);
      present0  = |cur_word0;
      present1  = |cur_word1;
      nxt_word0 = lane_update(s1_req.op, cur_word0);
      nxt_word1 = lane_update(s1_req.op, cur_word1);
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_en     <= 1'b0;
         rsp_valid <= 1'b0;
         hist_en   <= 1'b0;
      end else begin
         wr_en     <= s1_valid;
         rsp_valid <= s1_valid;  // one response per request, in order
         hist_en   <= wr_en;
      end
   end

   always_ff @(posedge clk) begin
      wr_addr0   <= s1_req.hash0;
      wr_addr1   <= s1_req.hash1;
      wr_word0   <= nxt_word0;
      wr_word1   <= nxt_word1;
      rsp.op     <= s1_req.op;
      rsp.tag    <= s1_req.tag;
      rsp.hit    <= present0 & present1;
      hist_addr0 <= wr_addr0;
      hist_addr1 <= wr_addr1;
      hist_word0 <= wr_word0;
      hist_word1 <= wr_word1;
   end

endmodule

// ==== verilog/bloom_filter_top.sv ====
`include "bf_defs.svh"

module bloom_filter_top
   import bf_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    req_valid,
   input  bf_req_t req,
   output logic    credit_return,
   output logic    rsp_valid,
   output bf_rsp_t rsp
);

   logic                     s1_valid;
   bf_req_t                  s1_req;
   logic [`BF_ADDR_BITS-1:0] rd_addr0;
   logic [`BF_ADDR_BITS-1:0] rd_addr1;
   bucket_word_t             rd_word0;
   bucket_word_t             rd_word1;
   logic                     wr_en;     // both banks write together
   logic [`BF_ADDR_BITS-1:0] wr_addr0;
   logic [`BF_ADDR_BITS-1:0] wr_addr1;
   bucket_word_t             wr_word0;
   bucket_word_t             wr_word1;

   bf_req_ingress u_ingress (
      .clk           (clk),
      .rst_n         (rst_n),
      .req_valid     (req_valid),
      .req           (req),
      .credit_return (credit_return),
      .s1_valid      (s1_valid),
      .s1_req        (s1_req),
      .rd_addr0      (rd_addr0),
      .rd_addr1      (rd_addr1)
   );

   // hash 0 bank
   bf_bucket_bank u_bank0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd_addr (rd_addr0),
      .wr_en   (wr_en),
      .wr_addr (wr_addr0),
      .wr_word (wr_word0),
      .rd_word (rd_word0)
   );

   // hash 1 bank
   bf_bucket_bank u_bank1 (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd_addr (rd_addr1),
      .wr_en   (wr_en),
      .wr_addr (wr_addr1),
      .wr_word (wr_word1),
      .rd_word (rd_word1)
   );

   bf_bucket_update u_update (
      .clk       (clk),
      .rst_n     (rst_n),
      .s1_valid  (s1_valid),
      .s1_req    (s1_req),
      .rd_word0  (rd_word0),
      .rd_word1  (rd_word1),
      .wr_en     (wr_en),
      .wr_addr0  (wr_addr0),
      .wr_addr1  (wr_addr1),
      .wr_word0  (wr_word0),
      .wr_word1  (wr_word1),
      .rsp_valid (rsp_valid),
      .rsp       (rsp)
   );

endmodule

// ==== verif/bf_checker.sv ====
`include "bf_defs.svh"

module bf_checker
   import bf_pkg::*;
(
   input logic         clk,
   input logic         rst_n,
   input logic         req_valid,
   input bf_req_t      req,
   input logic         credit_return,
   input logic         rsp_valid,
   input bf_rsp_t      rsp,
   input logic         wr_en,
   input bucket_word_t wr_word0,
   input bucket_word_t wr_word1
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int      NUM_WORDS = 1 << `BF_ADDR_BITS;
   localparam bucket_t TOP_COUNT = {`BF_BUCKET_BITS{1'b1}};

   typedef struct packed {
      bf_rsp_t      rsp;
      bucket_word_t word0;
      bucket_word_t word1;
   } expect_t;

   bucket_word_t model0 [NUM_WORDS];  // shadow of bank 0
   bucket_word_t model1 [NUM_WORDS];
   expect_t      exp_mem [16];
   logic [4:0]   exp_wr;
   logic [4:0]   exp_rd;
   logic [4:0]   exp_cnt;
   expect_t      exp_head;
   expect_t      exp_new;
   int           q_cnt;    // requests sitting in the ingress queue
   logic [2:0]   lat_sr;   // request entered an empty queue n+1 cycles ago

   logic fail_credit = 1'b0;
   logic fail_orphan = 1'b0;
   logic fail_rsp    = 1'b0;
   logic fail_word   = 1'b0;
   logic fail_lat    = 1'b0;
   logic fail_seen;

   // insert saturates slot 0, remove drains the lowest nonzero slot
   function automatic bucket_word_t apply_req(input bf_op_e op, input bucket_word_t w);
      bucket_word_t r;
      int           low;
      r   = w;
      low = -1;
      if (op == OP_INSERT) begin
         if (w[0] < TOP_COUNT) begin
            r[0] = w[0] + 1'b1;
         end
      end else begin
         for (int i = `BF_NUM_BUCKETS - 1; i >= 0; i--) begin
            if (w[i] != '0) low = i;
         end
         if (low >= 0) begin
            r[low] = w[low] - 1'b1;
         end
      end
      return r;
   endfunction

   always_comb begin
      exp_new.rsp.op  = req.op;
      exp_new.rsp.tag = req.tag;
      exp_new.rsp.hit = (model0[req.hash0] != '0) && (model1[req.hash1] != '0);
      exp_new.word0   = apply_req(req.op, model0[req.hash0]);
      exp_new.word1   = apply_req(req.op, model1[req.hash1]);
   end

   assign exp_head  = exp_mem[exp_rd[3:0]];
   assign exp_cnt   = exp_wr - exp_rd;
   assign fail_seen = fail_credit | fail_orphan | fail_rsp | fail_word | fail_lat;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int a = 0; a < NUM_WORDS; a++) begin
            model0[a] <= '0;
            model1[a] <= '0;
         end
         exp_wr <= '0;
         exp_rd <= '0;
         q_cnt  <= 0;
         lat_sr <= '0;
      end else begin
         if (req_valid) begin  // model runs in request order
            model0[req.hash0]    <= exp_new.word0;
            model1[req.hash1]    <= exp_new.word1;
            exp_mem[exp_wr[3:0]] <= exp_new;
            exp_wr               <= exp_wr + 1'b1;
         end
         if (rsp_valid && exp_cnt != '0) begin
            exp_rd <= exp_rd + 1'b1;
         end
         q_cnt  <= q_cnt + (req_valid ? 1 : 0) - (credit_return ? 1 : 0);
         lat_sr <= {lat_sr[1:0], req_valid && q_cnt == 0};
      end
   end

   a_credit: assert property (@(posedge clk) disable iff (!rst_n)
      credit_return |-> q_cnt > 0)
      else begin
         $error("credit returned at %0t with no request waiting in the queue", $time);
         fail_credit = 1'b1;
      end

   a_orphan: assert property (@(posedge clk) disable iff (!rst_n)
      (rsp_valid || wr_en) |-> (rsp_valid && wr_en && exp_cnt != '0))
      else begin
         $error("response or bank write at %0t with no request outstanding", $time);
         fail_orphan = 1'b1;
      end

   a_rsp: assert property (@(posedge clk) disable iff (!rst_n)
      (rsp_valid && exp_cnt != '0) |-> rsp == exp_head.rsp)
      else begin
         $error("MISMATCH %0t: rsp expected op %0d tag %0d hit %0b, got op %0d tag %0d hit %0b",
                $time, $sampled(exp_head.rsp.op), $sampled(exp_head.rsp.tag),
                $sampled(exp_head.rsp.hit), $sampled(rsp.op), $sampled(rsp.tag),
                $sampled(rsp.hit));
         fail_rsp = 1'b1;
      end

   a_word: assert property (@(posedge clk) disable iff (!rst_n)
      (rsp_valid && exp_cnt != '0) |->
         (wr_word0 == exp_head.word0 && wr_word1 == exp_head.word1))
      else begin
         $error("MISMATCH %0t: words expected %h %h, got %h %h", $time,
                $sampled(exp_head.word0), $sampled(exp_head.word1),
                $sampled(wr_word0), $sampled(wr_word1));
         fail_word = 1'b1;
      end

   a_latency: assert property (@(posedge clk) disable iff (!rst_n)
      lat_sr[2] |-> rsp_valid)
      else begin
         $error("MISMATCH %0t: rsp_valid expected 1 three cycles after request, got %0b",
                $time, $sampled(rsp_valid));
         fail_lat = 1'b1;
      end

endmodule

bind bloom_filter_top bf_checker u_checker (
   .clk           (clk),
   .rst_n         (rst_n),
   .req_valid     (req_valid),
   .req           (req),
   .credit_return (credit_return),
   .rsp_valid     (rsp_valid),
   .rsp           (rsp),
   .wr_en         (wr_en),
   .wr_word0      (wr_word0),
   .wr_word1      (wr_word1)
);

// ==== verif/bf_tb.sv ====
`include "bf_defs.svh"

module bf_tb
   import bf_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int N_FILL     = 20;   // drives counter 0 into saturation
   localparam int N_DRAIN    = 17;   // two more than needed to empty it
   localparam int N_RANDOM   = 400;
   localparam int N_TOTAL    = N_FILL + N_DRAIN + 1 + N_RANDOM;
   localparam int MAX_CYCLES = 8 * N_TOTAL + 200;

   localparam logic [`BF_ADDR_BITS-1:0] POOL0 [4] = '{6'd3, 6'd17, 6'd42, 6'd63};
   localparam logic [`BF_ADDR_BITS-1:0] POOL1 [4] = '{6'd5, 6'd17, 6'd40, 6'd63};

   logic    clk;
   logic    rst_n;
   logic    req_valid;
   bf_req_t req;
   logic    credit_return;
   logic    rsp_valid;
   bf_rsp_t rsp;

   integer  seed = 32'hdfe8961f;
   int      sent_cnt = 0;
   int      ret_cnt = 0;
   int      rsp_cnt = 0;
   int      cycle_cnt = 0;

   bloom_filter_top i_dut (
      .clk           (clk),
      .rst_n         (rst_n),
      .req_valid     (req_valid),
      .req           (req),
      .credit_return (credit_return),
      .rsp_valid     (rsp_valid),
      .rsp           (rsp)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always_ff @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (credit_return) ret_cnt <= ret_cnt + 1;
      if (rsp_valid) rsp_cnt <= rsp_cnt + 1;
   end

   task automatic stop_with_failure(input string why);
      $display("error at %0t: %s", $time, why);
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped");
   endtask

   // waits for a credit, then holds one request for a cycle
   task automatic send_req(input bf_op_e op, input logic [`BF_TAG_BITS-1:0] tag,
                           input logic [`BF_ADDR_BITS-1:0] h0,
                           input logic [`BF_ADDR_BITS-1:0] h1);
      while (sent_cnt - ret_cnt >= `BF_CREDITS) begin
         req_valid <= 1'b0;
         @(posedge clk);
      end
      req_valid <= 1'b1;
      req       <= '{op: op, tag: tag, hash0: h0, hash1: h1};
      sent_cnt++;
      @(posedge clk);
   endtask

   task automatic idle_cycles(input int n);
      req_valid <= 1'b0;
      repeat (n) @(posedge clk);
   endtask

   always @(posedge clk) begin
      if (cycle_cnt >= MAX_CYCLES) begin
         stop_with_failure("timeout, not every request got its response");
      end
   end

   initial begin
      wait (i_dut.u_checker.fail_seen === 1'b1);
      stop_with_failure("checker assertion failed");
   end

   initial begin
      int                      draw;
      bf_op_e                  op;
      logic [`BF_TAG_BITS-1:0] tag_seq;
      rst_n     = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      tag_seq   = '0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      idle_cycles(2);

      // one pair, inserted past the counter maximum
      for (int i = 0; i < N_FILL; i++) begin
         send_req(OP_INSERT, tag_seq, 6'd9, 6'd22);
         tag_seq = tag_seq + 1'b1;
      end
      idle_cycles(6);
      for (int i = 0; i < N_DRAIN; i++) begin
         send_req(OP_REMOVE, tag_seq, 6'd9, 6'd22);
         tag_seq = tag_seq + 1'b1;
      end
      idle_cycles(8);
      send_req(OP_REMOVE, tag_seq, 6'd50, 6'd51);  // pair never inserted
      idle_cycles(8);

      // small address pool, so collisions come back to back
      for (int i = 0; i < N_RANDOM; i++) begin
         draw = $random(seed);
         op   = (draw[2:0] < 3'd5) ? OP_INSERT : OP_REMOVE;
         send_req(op, draw[`BF_TAG_BITS+3:4], POOL0[draw[9:8]], POOL1[draw[11:10]]);
         if (draw[15:13] == 3'd0) begin
            idle_cycles(1 + int'(draw[17:16]));
         end
      end
      idle_cycles(1);

      wait (rsp_cnt == sent_cnt);
      repeat (4) @(posedge clk);
      if (i_dut.u_checker.fail_seen || ret_cnt != sent_cnt) begin
         stop_with_failure("checker errors or credits not all returned at end of run");
      end else begin
         $display("RESULT: PASS");
         $finish;
      end
   end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/bf_pkg.sv
verilog/bf_req_ingress.sv
verilog/bf_bucket_bank.sv
verilog/bf_bucket_update.sv
verilog/bloom_filter_top.sv
verif/bf_checker.sv
verif/bf_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= bf_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= RESULT: PASS

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard verilog/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)
